//--- bench/tb_gb_io.sv
// testbench for the memory and io glue
// clock, reset, bus stimulus tasks, reference state, checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_gb_io;
	import gb_pkg::*;

	logic clk_sys;
	logic reset_ss;
	logic is_cgb;
	addr_t cpu_addr;
	logic cpu_rd;
	logic cpu_wr;
	data_t cpu_do;
	logic irq_ack;
	logic [3:0] src;            // vblank, lcd, timer, serial
	logic [3:0] joy_din;
	logic dma_rd;
	addr_t dma_addr;
	data_t cpu_di;
	logic irq_n;
	logic [1:0] joy_p54;
	data_t dma_data;

	// reference state, built from the address map and register rules
	data_t wram_m [0:32767];
	data_t hram_m [0:127];
	irq_t ie_m = '0;
	irq_t if_m = '0;
	logic [2:0] svbk_m = 3'd1;
	logic [1:0] p54_m = 2'b11;

	logic chk_rd = 1'b0;        // armed in the strobe cycle
	logic chk_rd_q = 1'b0;      // result due now
	data_t exp_di;
	data_t exp_di_q;
	logic chk_dma = 1'b0;
	logic chk_dma_q = 1'b0;
	data_t exp_dma;
	data_t exp_dma_q;
	logic chk_irq = 1'b0;
	logic exp_irq_n;

	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int n_pass = 0;
	int n_fail = 0;
	integer seed = 32'h343;
	addr_t addr_q [$];          // work ram addresses already written

	gb_io_top u_dut (
		.clk_sys(clk_sys), .reset_ss(reset_ss), .is_cgb(is_cgb),
		.cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_do(cpu_do),
		.irq_ack(irq_ack), .vblank_irq(src[0]), .lcd_irq(src[1]),
		.timer_irq(src[2]), .serial_irq(src[3]), .joy_din(joy_din),
		.dma_rd(dma_rd), .dma_addr(dma_addr), .cpu_di(cpu_di), .irq_n(irq_n),
		.joy_p54(joy_p54), .dma_data(dma_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// run limit
	initial begin
		repeat (100000) @(posedge clk_sys);
		$display("timeout: the run did not finish within 100000 cycles");
		$display("RESULT: FAIL");
		$finish;
	end

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		chk_rd_q  <= chk_rd;        // one-cycle read latency
		exp_di_q  <= exp_di;
		chk_dma_q <= chk_dma;
		exp_dma_q <= exp_dma;
	end

	a_cpu_di: assert property (@(posedge clk_sys) disable iff (reset_ss)
		chk_rd_q |-> (cpu_di == exp_di_q))
		else begin
			errors++;
			$display("ERR cpu_di got %h expected %h", $sampled(cpu_di), $sampled(exp_di_q));
		end

	a_dma_data: assert property (@(posedge clk_sys) disable iff (reset_ss)
		chk_dma_q |-> (dma_data == exp_dma_q))
		else begin
			errors++;
			$display("ERR dma_data got %h expected %h", $sampled(dma_data),
				$sampled(exp_dma_q));
		end

	a_irq_n: assert property (@(posedge clk_sys) disable iff (reset_ss)
		chk_irq |-> (irq_n == exp_irq_n))
		else begin
			errors++;
			$display("ERR irq_n got %h expected %h", $sampled(irq_n), $sampled(exp_irq_n));
		end

	a_joy_p54: assert property (@(posedge clk_sys) disable iff (reset_ss)
		joy_p54 == p54_m)
		else begin
			errors++;
			$display("ERR joy_p54 got %h expected %h", $sampled(joy_p54), $sampled(p54_m));
		end

	// lower 4k bank 0, upper 4k the selected bank, dmg fixed to bank 1
	function automatic logic [14:0] wram_index(input addr_t a);
		logic [2:0] bank;
		bank = a[12] ? (is_cgb ? svbk_m : 3'd1) : 3'd0;
		return {bank, a[11:0]};
	endfunction

	function automatic data_t expect_byte(input addr_t a);
		if (a == ADDR_P1)
			return {2'b11, p54_m, joy_din};
		if (a == ADDR_IF)
			return {3'b111, if_m};      // unused bits read high
		if (a == ADDR_IE)
			return {3'b000, ie_m};
		if (a == ADDR_SVBK)
			return is_cgb ? {5'h1F, svbk_m} : OPEN_BUS;
		if (a >= 16'hC000 && a <= 16'hFDFF)
			return wram_m[wram_index(a)];
		if (a >= 16'hFF80 && a <= 16'hFFFE)
			return hram_m[a[6:0]];
		return OPEN_BUS;
	endfunction

	function automatic data_t expect_dma(input addr_t a);
		if (a >= 16'hC000 && a[15:8] <= DMA_LAST_PAGE)
			return wram_m[wram_index(a)];
		return OPEN_BUS;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic settle(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic cpu_write(input addr_t a, input data_t d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_do   = d;
		cpu_wr   = 1'b1;
		@(negedge clk_sys);
		cpu_wr = 1'b0;
		if (a == ADDR_P1)               // reference follows once written
			p54_m = d[5:4];
		else if (a == ADDR_IE)
			ie_m = d[4:0];
		else if (a == ADDR_IF)
			if_m = d[4:0];
		else if (a == ADDR_SVBK && is_cgb)
			svbk_m = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
		else if (a >= 16'hC000 && a <= 16'hFDFF)
			wram_m[wram_index(a)] = d;
		else if (a >= 16'hFF80 && a <= 16'hFFFE)
			hram_m[a[6:0]] = d;
	endtask

	task automatic cpu_read(input addr_t a);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_rd   = 1'b1;
		exp_di   = expect_byte(a);
		chk_rd   = 1'b1;
		checks++;
		@(negedge clk_sys);
		cpu_rd = 1'b0;
		chk_rd = 1'b0;
	endtask

	task automatic dma_read(input addr_t a);
		@(negedge clk_sys);
		dma_rd   = 1'b1;
		dma_addr = a;
		exp_dma  = expect_dma(a);
		chk_dma  = 1'b1;
		checks++;
		@(negedge clk_sys);
		dma_rd  = 1'b0;
		chk_dma = 1'b0;
	endtask

	// cpu access in the same cycle as a dma work ram read
	task automatic collide(input addr_t da, input addr_t ca, input logic wr);
		@(negedge clk_sys);
		dma_rd   = 1'b1;
		dma_addr = da;
		exp_dma  = expect_dma(da);
		chk_dma  = 1'b1;
		cpu_addr = ca;
		cpu_do   = ~expect_byte(ca);    // differs from the stored byte
		cpu_wr   = wr;
		cpu_rd   = !wr;
		chk_rd   = !wr;
		exp_di   = OPEN_BUS;            // cpu read loses to dma
		checks += wr ? 1 : 2;
		@(negedge clk_sys);
		dma_rd  = 1'b0;
		chk_dma = 1'b0;
		cpu_wr  = 1'b0;
		cpu_rd  = 1'b0;
		chk_rd  = 1'b0;
	endtask

	task automatic wait_irq_low;
		int n;
		n = 0;
		while (irq_n !== 1'b0 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (irq_n !== 1'b0) begin
			errors++;
			$display("timeout: irq_n did not fall within 8 cycles");
		end
	endtask

	task automatic check_irq_n;
		settle(3);
		exp_irq_n = ~|(ie_m & if_m);
		chk_irq   = 1'b1;
		checks++;
		@(negedge clk_sys);
		chk_irq = 1'b0;
	endtask

	task automatic pulse_source(input int i);
		@(negedge clk_sys);
		src[i]  = 1'b1;
		if_m[i] = 1'b1;
		if (|(ie_m & if_m))
			wait_irq_low();
		settle(2);
		src[i] = 1'b0;
	endtask

	// vector is base + 8 * lowest pending enabled index
	task automatic ack_irq;
		int idx;
		idx = 0;
		for (int i = IRQ_NUM - 1; i >= 0; i--)
			if (ie_m[i] && if_m[i])
				idx = i;
		@(negedge clk_sys);
		irq_ack = 1'b1;
		exp_di  = IRQ_VEC_BASE + data_t'(8 * idx);
		chk_rd  = 1'b1;
		checks++;
		@(negedge clk_sys);
		irq_ack   = 1'b0;
		chk_rd    = 1'b0;
		if_m[idx] = 1'b0;       // only the acknowledged bit goes
	endtask

	task automatic end_test(input string name);
		settle(2);              // let the last armed check fire
		if (errors == err_mark)
			n_pass++;
		else
			n_fail++;
		$display("test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		addr_t a;
		reset_ss = 1'b1;
		is_cgb   = 1'b1;
		cpu_addr = '0;
		cpu_rd   = 1'b0;
		cpu_wr   = 1'b0;
		cpu_do   = '0;
		irq_ack  = 1'b0;
		src      = '0;
		joy_din  = 4'hF;        // lines idle high
		dma_rd   = 1'b0;
		dma_addr = '0;
		exp_di   = '0;
		exp_dma  = '0;
		exp_irq_n = 1'b1;
		repeat (3) @(posedge clk_sys);  // three reset edges
		@(negedge clk_sys);
		reset_ss = 1'b0;

		check_irq_n();
		cpu_read(ADDR_IE);
		cpu_read(ADDR_IF);
		end_test("reset");

		for (int i = 0; i < 128; i++) begin
			a = 16'hC000 | addr_t'($random(seed) & 32'hFFF);
			cpu_write(a, data_t'($random(seed)));
			cpu_read(a);
			addr_q.push_back(a);
		end
		cpu_write(ADDR_SVBK, 8'h03);
		cpu_read(ADDR_SVBK);
		for (int k = 0; k < 64; k++)
			cpu_write(16'hD000 + addr_t'(k * 64), data_t'($random(seed)));
		cpu_write(ADDR_SVBK, 8'h00);    // stores bank 1
		cpu_read(ADDR_SVBK);
		for (int k = 0; k < 64; k++)
			cpu_write(16'hD000 + addr_t'(k * 64), data_t'($random(seed)));
		cpu_write(ADDR_SVBK, 8'h03);
		for (int k = 0; k < 64; k++) begin
			cpu_read(16'hD000 + addr_t'(k * 64));
			cpu_read(16'hF000 + addr_t'(k * 64));   // echo of the banked half
		end
		foreach (addr_q[i])
			cpu_read(addr_q[i] + 16'h2000);
		@(negedge clk_sys);
		is_cgb = 1'b0;
		cpu_read(ADDR_SVBK);
		for (int k = 0; k < 64; k++)
			cpu_read(16'hD000 + addr_t'(k * 64)); // dmg sees bank 1
		@(negedge clk_sys);
		is_cgb = 1'b1;
		end_test("wram");

		for (int i = 0; i < 127; i++)
			cpu_write(16'hFF80 + addr_t'(i), data_t'($random(seed)));
		for (int i = 0; i < 127; i++)
			cpu_read(16'hFF80 + addr_t'(i));
		cpu_read(16'hFF01);
		cpu_read(16'hFF50);
		cpu_read(16'hFF7F);
		cpu_read(16'hFE00);
		end_test("hram");

		cpu_write(ADDR_IE, 8'h1F);
		for (int i = 0; i < 4; i++) begin
			pulse_source(i);
			check_irq_n();
			cpu_read(ADDR_IF);
		end
		cpu_write(ADDR_IE, 8'h00);
		check_irq_n();
		cpu_write(ADDR_IE, 8'h0C);      // timer and serial only
		check_irq_n();
		ack_irq();
		cpu_read(ADDR_IF);
		check_irq_n();
		ack_irq();
		cpu_read(ADDR_IF);
		check_irq_n();
		cpu_write(ADDR_IF, 8'h00);
		end_test("irq");

		cpu_write(ADDR_IE, 8'h10);
		cpu_write(ADDR_P1, 8'h10);
		cpu_read(ADDR_P1);
		cpu_write(ADDR_P1, 8'h20);
		cpu_read(ADDR_P1);
		@(negedge clk_sys);
		joy_din = 4'hB;                 // line 2 pressed
		if_m[IRQ_JOYPAD] = 1'b1;
		wait_irq_low();
		check_irq_n();
		cpu_read(ADDR_IF);
		cpu_read(ADDR_P1);
		@(negedge clk_sys);
		joy_din = 4'hF;
		settle(4);
		cpu_write(ADDR_IF, 8'h00);
		check_irq_n();
		end_test("joypad");

		for (int i = 0; i < 256; i++)
			cpu_write(16'hC000 + addr_t'(i), data_t'($random(seed)));
		for (int i = 0; i < 256; i++)
			dma_read(16'hC000 + addr_t'(i));
		dma_read(16'hF200);
		collide(16'hC020, 16'hC010, 1'b1);
		cpu_read(16'hC010);             // old byte survives
		collide(16'hC030, 16'hC040, 1'b0);
		end_test("dma");

		$display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
			n_pass, n_fail, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
source/gb_pkg.sv
source/gb_ram.sv
source/gb_joypad.sv
source/gb_irq_ctrl.sv
source/gb_wram_arbiter.sv
source/gb_cpu_bus.sv
source/gb_io_top.sv
bench/tb_gb_io.sv

//--- source/gb_cpu_bus.sv
// cpu address decode into one-hot peer selects
// registered read select and read-return multiplexer with hold
`timescale 1ns/1ps
`default_nettype none

module gb_cpu_bus (
	input  wire            clk_sys,
	input  wire            reset_ss,
	input  gb_pkg::addr_t  cpu_addr,
	input  wire            cpu_rd,
	input  wire            irq_ack,
	input  wire            is_cgb,
	input  gb_pkg::data_t  irq_vec,
	input  gb_pkg::data_t  irq_do,
	input  gb_pkg::data_t  joy_do,
	input  gb_pkg::data_t  wram_do,
	input  gb_pkg::data_t  hram_do,
	input  gb_pkg::data_t  svbk_do,
	output logic           sel_p1,
	output logic           sel_if,
	output logic           sel_ie,
	output logic           sel_svbk,
	output logic           sel_wram,
	output logic           sel_hram,
	output gb_pkg::data_t  cpu_di
);
	import gb_pkg::*;

	cpu_addr_u ca;
	logic [4:0] sel_q;      // select of the read cycle
	logic rd_q;             // a read or ack result is due this cycle
	logic ack_q;
	data_t rd_byte;
	data_t hold_q;          // last result, shown between reads

	assign ca = cpu_addr;

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	assign sel_p1   = (cpu_addr == ADDR_P1);
	assign sel_if   = (cpu_addr == ADDR_IF);
	assign sel_ie   = (cpu_addr == ADDR_IE);
	assign sel_svbk = is_cgb && (cpu_addr == ADDR_SVBK);    // dmg reads open bus
	assign sel_wram = (ca.wram_v.region[2:1] == 2'b11) &&
	                  (ca.page_v.page <= WRAM_LAST_PAGE);    // c000..fdff incl. echo
	assign sel_hram = (ca.page_v.page == PAGE_HRAM) && ca.page_v.offset[7] &&
	                  (cpu_addr != ADDR_IE);

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			rd_q   <= 1'b0;
			ack_q  <= 1'b0;
			sel_q  <= '0;
			hold_q <= OPEN_BUS;
		end else begin
			rd_q  <= cpu_rd | irq_ack;
			ack_q <= irq_ack;
			sel_q <= cpu_rd ? {sel_p1, sel_if | sel_ie, sel_svbk, sel_wram, sel_hram}
			                : '0;
			if (rd_q)
				hold_q <= rd_byte;      // keep result until next read
		end
	end

	// return mux, one cycle after the read
	always_comb begin
		if (ack_q)             rd_byte = irq_vec;   // vector wins during ack
		else if (sel_q[4])     rd_byte = joy_do;
		else if (sel_q[3])     rd_byte = irq_do;
		else if (sel_q[2])     rd_byte = svbk_do;
		else if (sel_q[1])     rd_byte = wram_do;
		else if (sel_q[0])     rd_byte = hram_do;
		else                   rd_byte = OPEN_BUS;
	end

	assign cpu_di = rd_q ? rd_byte : hold_q;

	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$onehot0({sel_p1, sel_if, sel_ie, sel_svbk, sel_wram, sel_hram}))
		else $error("more than one peer selected");

endmodule

`default_nettype wire

//--- source/gb_io_top.sv
// top level of the memory and io glue
// cpu bus decode, interrupts, work ram with arbiter, high ram, joypad
`timescale 1ns/1ps
`default_nettype none

module gb_io_top #(
	parameter int WRAM_AW = 15,     // 32k work ram
	parameter int HRAM_AW = 7       // 127 byte high ram
) (
	input  wire            clk_sys,
	input  wire            reset_ss,
	input  wire            is_cgb,
	input  gb_pkg::addr_t  cpu_addr,
	input  wire            cpu_rd,
	input  wire            cpu_wr,
	input  gb_pkg::data_t  cpu_do,
	input  wire            irq_ack,
	input  wire            vblank_irq,
	input  wire            lcd_irq,
	input  wire            timer_irq,
	input  wire            serial_irq,
	input  wire [3:0]      joy_din,
	input  wire            dma_rd,
	input  gb_pkg::addr_t  dma_addr,
	output gb_pkg::data_t  cpu_di,
	output logic           irq_n,
	output logic [1:0]     joy_p54,
	output gb_pkg::data_t  dma_data
);
	import gb_pkg::*;

	logic sel_p1, sel_if, sel_ie, sel_svbk, sel_wram, sel_hram;
	logic joy_irq;
	irq_t irq_src;
	data_t irq_vec, irq_do, joy_do, wram_do, hram_do, svbk_do;
	logic [WRAM_AW-1:0] wram_addr;
	logic wram_we;
	data_t wram_d, wram_q;

	// ------------------------------------------------------------------------
	// interrupt sources
	// ------------------------------------------------------------------------
	assign irq_src[IRQ_VBLANK] = vblank_irq;
	assign irq_src[IRQ_LCD]    = lcd_irq;
	assign irq_src[IRQ_TIMER]  = timer_irq;
	assign irq_src[IRQ_SERIAL] = serial_irq;
	assign irq_src[IRQ_JOYPAD] = joy_irq;

	gb_cpu_bus u_cpu_bus (
		.clk_sys, .reset_ss, .cpu_addr, .cpu_rd, .irq_ack, .is_cgb,
		.irq_vec, .irq_do, .joy_do, .wram_do, .hram_do, .svbk_do,
		.sel_p1, .sel_if, .sel_ie, .sel_svbk, .sel_wram, .sel_hram, .cpu_di
	);

	gb_irq_ctrl u_irq_ctrl (
		.clk_sys, .reset_ss, .irq_src, .sel_if, .sel_ie, .cpu_rd, .cpu_wr,
		.cpu_do, .irq_ack, .irq_n, .irq_vec, .irq_do
	);

	gb_wram_arbiter #(.ADDR_W(WRAM_AW)) u_wram_arbiter (
		.clk_sys, .reset_ss, .is_cgb, .cpu_addr, .cpu_rd, .cpu_wr, .cpu_do,
		.sel_wram, .sel_svbk, .dma_rd, .dma_addr, .ram_q(wram_q),
		.ram_addr(wram_addr), .ram_we(wram_we), .ram_d(wram_d),
		.wram_do, .svbk_do, .dma_data
	);

	gb_ram #(.ADDR_W(WRAM_AW)) u_wram (
		.clk_sys, .addr(wram_addr), .we(wram_we), .d(wram_d), .q(wram_q)
	);

	gb_ram #(.ADDR_W(HRAM_AW)) u_hram (
		.clk_sys, .addr(cpu_addr[HRAM_AW-1:0]), .we(sel_hram & cpu_wr),
		.d(cpu_do), .q(hram_do)
	);

	gb_joypad u_joypad (
		.clk_sys, .reset_ss, .sel_p1, .cpu_wr, .cpu_do, .joy_din,
		.joy_p54, .joy_do, .joy_irq
	);

endmodule

`default_nettype wire

//--- source/gb_irq_ctrl.sv
// interrupt controller
// ie and if registers, rising-edge capture of the sources,
// priority vector and clear when the acknowledge ends
`timescale 1ns/1ps
`default_nettype none

module gb_irq_ctrl (
	input  wire            clk_sys,
	input  wire            reset_ss,
	input  gb_pkg::irq_t   irq_src,
	input  wire            sel_if,
	input  wire            sel_ie,
	input  wire            cpu_rd,
	input  wire            cpu_wr,
	input  gb_pkg::data_t  cpu_do,
	input  wire            irq_ack,
	output logic           irq_n,
	output gb_pkg::data_t  irq_vec,
	output gb_pkg::data_t  irq_do
);
	import gb_pkg::*;

	irq_t ie_r;
	irq_t if_r;
	irq_t src_q;            // sync stage
	irq_t src_qq;           // edge reference
	irq_t if_set;
	irq_t pend;
	irq_t lowest;           // one-hot of the winning request
	irq_t ack_clr;
	logic ack_q;

	assign if_set  = src_q & ~src_qq;                  // low to high on a source
	assign pend    = ie_r & if_r;
	assign irq_n   = ~|pend;
	assign ack_clr = (ack_q & ~irq_ack) ? lowest : '0; // ack just ended

	// priority, lowest index first
	always_comb begin
		lowest  = '0;
		irq_vec = 8'h00;        // nothing pending
		for (int i = IRQ_NUM - 1; i >= 0; i--) begin
			if (pend[i]) begin
				lowest  = irq_t'(1) << i;
				irq_vec = IRQ_VEC_BASE + data_t'(8 * i);
			end
		end
	end

	// ------------------------------------------------------------------------
	// flag and enable registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_r   <= '0;
			if_r   <= '0;
			src_q  <= '0;
			src_qq <= '0;
			ack_q  <= 1'b0;
		end else begin
			src_q  <= irq_src;
			src_qq <= src_q;
			ack_q  <= irq_ack;
			if (sel_ie && cpu_wr)
				ie_r <= cpu_do[4:0];
			if (sel_if && cpu_wr)
				if_r <= cpu_do[4:0];                   // cpu write overrides
			else
				if_r <= (if_r & ~ack_clr) | if_set;    // new edge beats the clear
		end
	end

	// read byte, unused bits float high in if
	always_ff @(posedge clk_sys) begin
		if (cpu_rd && (sel_if || sel_ie))
			irq_do <= sel_ie ? {3'b000, ie_r} : {3'b111, if_r};
	end

	// request line and vector agree with the enabled flags
	a_irq_n: assert property (@(posedge clk_sys) disable iff (reset_ss)
		(!irq_n == |(ie_r & if_r)) && (irq_n == (irq_vec == 8'h00)))
		else $error("irq_n does not match ie and if");

endmodule

`default_nettype wire

//--- source/gb_joypad.sv
// joypad p1 select register and read byte
// falling-edge interrupt request on the input lines
`timescale 1ns/1ps
`default_nettype none

module gb_joypad (
	input  wire            clk_sys,
	input  wire            reset_ss,
	input  wire            sel_p1,
	input  wire            cpu_wr,
	input  gb_pkg::data_t  cpu_do,
	input  wire [3:0]      joy_din,
	output logic [1:0]     joy_p54,
	output gb_pkg::data_t  joy_do,
	output logic           joy_irq
);
	logic [3:0] din_q;      // first sync stage
	logic [3:0] din_qq;     // previous sample

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54 <= 2'b11;   // no row selected
			din_q   <= 4'hF;    // lines idle high
			din_qq  <= 4'hF;
		end else begin
			din_q  <= joy_din;
			din_qq <= din_q;
			if (sel_p1 && cpu_wr)
				joy_p54 <= cpu_do[5:4];
		end
	end

	always_ff @(posedge clk_sys) begin
		joy_do <= {2'b11, joy_p54, joy_din};
	end

	// one-cycle pulse, any line going low
	assign joy_irq = |(din_qq & ~din_q);

endmodule

`default_nettype wire

//--- source/gb_pkg.sv
// shared definitions for the console memory and io glue
// address map constants, interrupt numbering, cpu address union
`default_nettype none

package gb_pkg;

	typedef logic [15:0] addr_t;               // cpu or dma address
	typedef logic [7:0]  data_t;               // one data byte
	typedef logic [4:0]  irq_t;                // one bit per interrupt source

	// ------------------------------------------------------------------------
	// two views of one cpu address
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [7:0] page;                      // high byte, ff for the register page
		logic [7:0] offset;
	} page_view_t;

	typedef struct packed {
		logic [2:0]  region;                   // 11x is work ram and its echo
		logic        upper;                    // upper 4k, banked by svbk
		logic [11:0] offset;
	} wram_view_t;

	typedef union packed {
		page_view_t page_v;                    // hram and registers
		wram_view_t wram_v;                    // work ram and banks
	} cpu_addr_u;

	// address map
	localparam addr_t ADDR_P1        = 16'hFF00;
	localparam addr_t ADDR_IF        = 16'hFF0F;
	localparam addr_t ADDR_SVBK      = 16'hFF70;
	localparam addr_t ADDR_IE        = 16'hFFFF;
	localparam logic [7:0] PAGE_HRAM      = 8'hFF;   // ff80..fffe
	localparam logic [7:0] WRAM_LAST_PAGE = 8'hFD;   // e000..fdff echoes c000..ddff
	localparam logic [7:0] DMA_LAST_PAGE  = 8'hF1;   // dma source limit

	// interrupt numbering, lowest index wins
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;
	localparam int IRQ_NUM    = 5;
	localparam data_t IRQ_VEC_BASE = 8'h40;     // + 8 * index

	localparam data_t OPEN_BUS = 8'hFF;         // unmapped reads

endpackage

`default_nettype wire

//--- source/gb_ram.sv
// single-port synchronous ram, old data on read during write
`timescale 1ns/1ps
`default_nettype none

module gb_ram #(
	parameter int ADDR_W = 15
) (
	input  wire                clk_sys,
	input  wire [ADDR_W-1:0]   addr,
	input  wire                we,
	input  gb_pkg::data_t      d,
	output gb_pkg::data_t      q
);
	import gb_pkg::*;

	data_t mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= d;
		q <= mem[addr];         // read sees the byte before this write
	end

endmodule

`default_nettype wire

//--- source/gb_wram_arbiter.sv
// work ram arbiter between cpu and oam dma read port
// svbk bank register, address mapping, dma priority and owner tracking
`timescale 1ns/1ps
`default_nettype none

module gb_wram_arbiter #(
	parameter int ADDR_W = 15
) (
	input  wire                 clk_sys,
	input  wire                 reset_ss,
	input  wire                 is_cgb,
	input  gb_pkg::addr_t       cpu_addr,
	input  wire                 cpu_rd,
	input  wire                 cpu_wr,
	input  gb_pkg::data_t       cpu_do,
	input  wire                 sel_wram,
	input  wire                 sel_svbk,
	input  wire                 dma_rd,
	input  gb_pkg::addr_t       dma_addr,
	input  gb_pkg::data_t       ram_q,
	output logic [ADDR_W-1:0]   ram_addr,
	output logic                ram_we,
	output gb_pkg::data_t       ram_d,
	output gb_pkg::data_t       wram_do,
	output gb_pkg::data_t       svbk_do,
	output gb_pkg::data_t       dma_data
);
	import gb_pkg::*;

	cpu_addr_u ca;
	cpu_addr_u da;
	logic [2:0] svbk_r;
	logic [2:0] bank;
	logic dma_wram;         // dma owns the ram this cycle
	logic dma_q;
	logic cpu_blk_q;        // cpu read lost to dma

	assign ca = cpu_addr;
	assign da = dma_addr;

	// lower 4k bank 0, upper 4k the selected bank
	function automatic logic [14:0] map_addr(input cpu_addr_u a, input logic [2:0] bk);
		map_addr = {a.wram_v.upper ? bk : 3'd0, a.wram_v.offset};
	endfunction

	assign bank     = is_cgb ? svbk_r : 3'd1;           // dmg has only bank 1
	assign dma_wram = dma_rd && (da.wram_v.region[2:1] == 2'b11) &&
	                  (da.page_v.page <= DMA_LAST_PAGE);

	// ------------------------------------------------------------------------
	// ram port
	// ------------------------------------------------------------------------
	assign ram_addr = ADDR_W'(dma_wram ? map_addr(da, bank) : map_addr(ca, bank));
	assign ram_we   = sel_wram && cpu_wr && !dma_wram;  // write dropped under dma
	assign ram_d    = cpu_do;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			svbk_r    <= 3'd1;
			dma_q     <= 1'b0;
			cpu_blk_q <= 1'b0;
		end else begin
			dma_q     <= dma_wram;
			cpu_blk_q <= sel_wram && cpu_rd && dma_wram;
			if (sel_svbk && cpu_wr)
				svbk_r <= (cpu_do[2:0] == 3'd0) ? 3'd1 : cpu_do[2:0];   // 0 -> 1
		end
	end

	always_ff @(posedge clk_sys) begin
		svbk_do <= {5'h1F, svbk_r};
	end

	// route ram output to the owner of the last cycle
	assign dma_data = dma_q ? ram_q : OPEN_BUS;
	assign wram_do  = cpu_blk_q ? OPEN_BUS : ram_q;

	a_dma_owns: assert property (@(posedge clk_sys) disable iff (reset_ss)
		dma_wram |-> !ram_we)
		else $error("cpu write reached work ram during dma read");

endmodule

`default_nettype wire
